/* vlog.f */
vga_pkg.sv
vga_timing.sv
vga_regs.sv
vga_pattern.sv
vga_out.sv
vga_top.sv
tb_vga.sv

/* run.sh */
#!/usr/bin/env bash
# compiles the VGA testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_vga -Mdir obj_dir -f vlog.f

out="$(./obj_dir/Vtb_vga)"
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

/* tb_vga.sv */
`timescale 1ns/1ps

// testbench for the VGA display controller
// the pixel position is rebuilt from the sync pins alone, and every pixel at
// the pins is compared with a colour model of the pattern rules
module tb_vga import vga_pkg::*; ();

	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int V_ACTIVE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int CLK_DIV = 2;
	localparam int CELL_LOG2 = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int CELL = 1 << CELL_LOG2;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 10;
	localparam int RESET_CYCLES = 16;
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * CLK_DIV;
	// the five tests run for about ten frames at the pins, two more are spare
	localparam int RUN_FRAMES = 12;
	localparam int WATCHDOG_NS = (RESET_CYCLES + RUN_FRAMES * FRAME_CLKS) * CLK_PERIOD;

	logic          clk;
	logic          rst;
	logic          wr;
	logic [1:0]    addr;
	vga_reg_word_u wdata;
	logic          pix_en;
	rgb_t          rgb_pin;
	logic          hsync_pin;
	logic          vsync_pin;

	// colour model, with pending and live copies like the register block
	vga_ctrl_t live_ctrl, pend_ctrl;
	rgb_t      live_fg, pend_fg, live_bg, pend_bg, exp_rgb;
	logic      pend_dirty;

	// position tracker and sync measurement, all counted in strobes
	logic prev_hs, prev_vs, hs_rise, hs_fall, vs_rise, vs_fall;
	logic seen_h, seen_v, trk_valid, h_armed, v_armed;
	int   h_pos, line_pos, cur_x, cur_y, frame_cnt;
	int   h_low, h_gap, v_low, v_gap, h_period_checks, v_period_checks;

	// strobe rate, counted in clocks
	int   clk_gap;
	logic pe_armed;

	string test_name;
	int    test_num, test_errs, test_checks, old_checks;
	int    total_errs, total_checks, tests_passed, tests_failed;
	int    seed;

	vga_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.CLK_DIV(CLK_DIV), .CELL_LOG2(CELL_LOG2)
	) uut (
		.clk(clk), .rst(rst), .wr(wr), .addr(addr), .wdata(wdata), .pix_en(pix_en),
		.rgb_pin(rgb_pin), .hsync_pin(hsync_pin), .vsync_pin(vsync_pin)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// colour that the pattern rules give for one pin position
	// cells are CELL pixels wide, and the odd cells take the background
	function automatic rgb_t expected_color(int x, int y, vga_ctrl_t c, rgb_t f, rgb_t b);
		logic x_odd;
		logic y_odd;
		logic on_line;
		x_odd = ((x / CELL) % 2) == 1;
		y_odd = ((y / CELL) % 2) == 1;
		on_line = (x % CELL == 0) || (y % CELL == 0);
		if (!c.video_on || x >= H_ACTIVE || y >= V_ACTIVE)
			return '0;
		case (c.mode)
			mode_bars:    return x_odd ? b : f;
			mode_checker: return (x_odd == y_odd) ? f : b;
			mode_grid:    return on_line ? f : b;
			default:      return f;
		endcase
	endfunction

	task automatic note_error();
		test_errs++;
		total_errs++;
	endtask

	task automatic check_int(string what, int expected, int actual);
		test_checks++;
		assert (actual == expected) else begin
			$display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
			note_error();
		end
	endtask

	task automatic check_idle_pins();
		test_checks++;
		assert (hsync_pin === 1'b1 && vsync_pin === 1'b1 && rgb_pin === 12'h000) else begin
			$display("[ERROR] %s: pins expected hsync 1 vsync 1 rgb 000 actual %b %b %h",
				test_name, hsync_pin, vsync_pin, rgb_pin);
			note_error();
		end
	endtask

	// the strobe has to come exactly once every CLK_DIV clocks
	always @(negedge clk) begin
		if (!rst) begin
			clk_gap++;
			if (pix_en) begin
				if (pe_armed)
					check_int("pix_en period", CLK_DIV, clk_gap);
				pe_armed = 1'b1;
				clk_gap = 0;
			end
		end
	end

	// one sample per strobe, taken at the falling edge while the pins are steady
	always @(negedge clk) begin
		if (!rst && pix_en) begin
			hs_rise = hsync_pin && !prev_hs;
			hs_fall = !hsync_pin && prev_hs;
			vs_rise = vsync_pin && !prev_vs;
			vs_fall = !vsync_pin && prev_vs;
			h_gap++;
			v_gap++;
			if (!hsync_pin)
				h_low++;
			if (!vsync_pin)
				v_low++;
			if (hs_rise) begin
				check_int("hsync low width", H_SYNC, h_low);
				h_low = 0;
			end
			if (vs_rise) begin
				check_int("vsync low width", V_SYNC * H_TOTAL, v_low);
				v_low = 0;
			end
			// periods run from one falling edge to the next
			if (hs_fall) begin
				if (h_armed) begin
					check_int("hsync period", H_TOTAL, h_gap);
					h_period_checks++;
				end
				h_armed = 1'b1;
				h_gap = 0;
			end
			if (vs_fall) begin
				if (v_armed) begin
					check_int("vsync period", V_TOTAL * H_TOTAL, v_gap);
					v_period_checks++;
				end
				v_armed = 1'b1;
				v_gap = 0;
			end
			// the back porch follows the sync pulse, so the column is the
			// strobe count since hsync rose minus H_BACK, and rows work the same
			if (hs_rise) begin
				h_pos = 0;
				seen_h = 1'b1;
			end else begin
				h_pos++;
			end
			cur_x = (h_pos + H_TOTAL - H_BACK) % H_TOTAL;
			if (vs_rise) begin
				line_pos = 0;
				seen_v = 1'b1;
			end else if (cur_x == 0) begin
				line_pos++;
			end
			cur_y = (line_pos + V_TOTAL - V_BACK) % V_TOTAL;
			trk_valid = seen_h && seen_v;
			if (trk_valid) begin
				// the top left pixel is the first one drawn with new settings
				if (cur_x == 0 && cur_y == 0) begin
					live_ctrl = pend_ctrl;
					live_fg = pend_fg;
					live_bg = pend_bg;
					pend_dirty = 1'b0;
					frame_cnt++;
				end
				if (pend_dirty)
					old_checks++;
				exp_rgb = expected_color(cur_x, cur_y, live_ctrl, live_fg, live_bg);
				test_checks++;
				assert (rgb_pin === exp_rgb) else begin
					$display("[ERROR] %s: pixel (%0d,%0d) expected %h actual %h",
						test_name, cur_x, cur_y, exp_rgb, rgb_pin);
					note_error();
				end
			end
			prev_hs = hsync_pin;
			prev_vs = vsync_pin;
		end
	end

	task automatic begin_test(int num, string name);
		test_num = num;
		test_name = name;
		test_errs = 0;
		test_checks = 0;
	endtask

	task automatic end_test();
		if (test_checks == 0) begin
			$display("test %0d %s never reached any of its checks", test_num, test_name);
			note_error();
		end
		if (test_errs == 0)
			tests_passed++;
		else
			tests_failed++;
		total_checks += test_checks;
		$display("test %0d %s: %s, %0d checks, %0d errors", test_num, test_name,
			(test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
	endtask

	// one write strobe, and the same value goes into the model's pending copy
	task automatic write_reg(logic [1:0] reg_addr, vga_reg_word_u word);
		@(posedge clk);
		#DRIVE_DLY;
		wr = 1'b1;
		addr = reg_addr;
		wdata = word;
		@(posedge clk);
		#DRIVE_DLY;
		wr = 1'b0;
		case (reg_addr)
			reg_ctrl: pend_ctrl = word.ctrl;
			reg_fg:   pend_fg = word.color;
			default:  pend_bg = word.color;
		endcase
		pend_dirty = 1'b1;
	endtask

	task automatic write_ctrl(logic on, vga_mode_e mode);
		vga_reg_word_u word;
		word.ctrl.reserved = '0;
		word.ctrl.video_on = on;
		word.ctrl.mode = mode;
		write_reg(reg_ctrl, word);
	endtask

	task automatic write_random_colors();
		logic [31:0]   r;
		vga_reg_word_u fg_word;
		vga_reg_word_u bg_word;
		r = $random(seed);
		fg_word.color = r[11:0];
		bg_word.color = r[27:16];
		// equal colours would hide a wrong cell decode
		if (r[27:16] == r[11:0])
			bg_word.color = ~r[11:0];
		write_reg(reg_fg, fg_word);
		write_reg(reg_bg, bg_word);
	endtask

	task automatic wait_frames(int n);
		int target;
		target = frame_cnt + n;
		wait (frame_cnt >= target);
	endtask

	task automatic wait_row(int row);
		wait (trk_valid && cur_y == row);
	endtask

	initial begin
		seed = 32'h6b460c3f;
		rst = 1'b1;
		wr = 1'b0;
		addr = 2'd0;
		wdata = '0;
		pend_ctrl = '{reserved: 9'd0, video_on: 1'b0, mode: mode_solid};
		pend_fg = '{red: 4'hf, green: 4'hf, blue: 4'hf};
		pend_bg = '{red: 4'h0, green: 4'h0, blue: 4'h0};
		live_ctrl = pend_ctrl;
		live_fg = pend_fg;
		live_bg = pend_bg;
		pend_dirty = 1'b0;
		clk_gap = 0;
		pe_armed = 1'b0;
		{prev_hs, prev_vs, seen_h, seen_v, trk_valid, h_armed, v_armed} = 7'b1100000;
		{h_pos, line_pos, cur_x, cur_y, frame_cnt} = '0;
		{h_low, h_gap, v_low, v_gap, h_period_checks, v_period_checks} = '0;
		{old_checks, total_errs, total_checks, tests_passed, tests_failed} = '0;

		begin_test(1, "reset state");
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_idle_pins();
			check_int("pix_en during reset", 0, pix_en);
		end
		@(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_idle_pins();
		end
		end_test();

		begin_test(2, "sync geometry");
		wait (h_period_checks >= 3 && v_period_checks >= 1);
		end_test();

		// a whole frame with video off, then one with the default white on
		begin_test(3, "blanking");
		wait_frames(1);
		wait_row(1);
		write_ctrl(1'b1, mode_solid);
		wait_frames(2);
		end_test();

		begin_test(4, "solid and bars");
		wait_row(1);
		write_random_colors();
		write_ctrl(1'b1, mode_solid);
		wait_frames(1);
		wait_row(1);
		write_ctrl(1'b1, mode_bars);
		wait_frames(2);
		end_test();

		// the grid write lands in the middle of a checker frame
		begin_test(5, "checker and grid");
		wait_row(1);
		write_ctrl(1'b1, mode_checker);
		wait_frames(1);
		wait_row(4);
		old_checks = 0;
		write_random_colors();
		write_ctrl(1'b1, mode_grid);
		wait_frames(2);
		if (old_checks == 0) begin
			$display("test 5 checked no pixel against the old settings after the write");
			note_error();
		end
		end_test();

		$display("tests: %0d passed, %0d failed, %0d checks, %0d errors",
			tests_passed, tests_failed, total_checks, total_errs);
		if (total_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: test %0d %s did not finish within %0d ns",
			test_num, test_name, WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* vga_top.sv */
`timescale 1ns/1ps

// VGA display controller top level
// timing generator, configuration registers, pattern generator and output
// stage in a three stage chain that advances on the pixel strobe
module vga_top import vga_pkg::*; #(
	parameter int H_ACTIVE  = 640,
	parameter int H_FRONT   = 16,
	parameter int H_SYNC    = 96,
	parameter int H_BACK    = 48,
	parameter int V_ACTIVE  = 480,
	parameter int V_FRONT   = 10,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 33,
	parameter int CLK_DIV   = 4,
	parameter int CELL_LOG2 = 3
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          wr,
	input  logic [1:0]    addr,
	input  vga_reg_word_u wdata,
	output logic          pix_en,
	output rgb_t          rgb_pin,
	output logic          hsync_pin,
	output logic          vsync_pin
);

	vga_beat_t beat_tim;
	vga_beat_t beat_pat;
	logic      frame_start;
	vga_ctrl_t ctrl;
	rgb_t      fg;
	rgb_t      bg;
	rgb_t      color;

	vga_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.CLK_DIV(CLK_DIV)
	) u_timing (
		.clk(clk), .rst(rst), .pix_en(pix_en), .beat(beat_tim),
		.frame_start(frame_start)
	);

	// new settings are taken over on the strobe that loads the first beat
	vga_regs u_regs (
		.clk(clk), .rst(rst), .wr(wr), .addr(addr), .wdata(wdata),
		.frame_start(frame_start), .ctrl(ctrl), .fg(fg), .bg(bg)
	);

	vga_pattern #(.CELL_LOG2(CELL_LOG2)) u_pattern (
		.clk(clk), .rst(rst), .pix_en(pix_en), .beat_in(beat_tim), .ctrl(ctrl),
		.fg(fg), .bg(bg), .beat_out(beat_pat), .color(color)
	);

	// video_on is read one strobe after the pattern used the same settings,
	// which is still inside the frame they were loaded for
	vga_out u_out (
		.clk(clk), .rst(rst), .pix_en(pix_en), .beat(beat_pat), .color(color),
		.video_on(ctrl.video_on), .rgb_pin(rgb_pin), .hsync_pin(hsync_pin),
		.vsync_pin(vsync_pin)
	);

endmodule

/* vga_out.sv */
`timescale 1ns/1ps

// output stage
// blanks the colour outside the visible window and registers colour and
// both syncs to the pins on the same strobe
module vga_out import vga_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      pix_en,
	input  vga_beat_t beat,
	input  rgb_t      color,
	input  logic      video_on,
	output rgb_t      rgb_pin,
	output logic      hsync_pin,
	output logic      vsync_pin
);

	logic show;

	// monitors need black during the porches to find the black level,
	// and the host can switch the picture off without touching the syncs
	assign show = beat.active && video_on;

	// pin registers
	// out of reset the syncs idle high and the colour is black
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb_pin <= '0;
			hsync_pin <= 1'b1;
			vsync_pin <= 1'b1;
		end else if (pix_en) begin
			rgb_pin <= show ? color : rgb_t'('0);
			hsync_pin <= beat.hsync;
			vsync_pin <= beat.vsync;
		end
	end

	// nothing may reach the pins from a beat outside the visible window
	assert property (@(posedge clk) disable iff (rst)
		(pix_en && !beat.active) |=> (rgb_pin == '0));

endmodule

/* vga_pattern.sv */
`timescale 1ns/1ps

// pattern generator
// turns the position in each timing beat into a colour and passes the beat on
// one strobe later, so colour and sync stay paired
module vga_pattern import vga_pkg::*; #(
	parameter int CELL_LOG2 = 3
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      pix_en,
	input  vga_beat_t beat_in,
	input  vga_ctrl_t ctrl,
	input  rgb_t      fg,
	input  rgb_t      bg,
	output vga_beat_t beat_out,
	output rgb_t      color
);

	// cells are 2**CELL_LOG2 pixels wide and high
	// CELL_LOG2 has to be at least 1 for the grid lines to exist
	logic x_cell;
	logic y_cell;
	logic x_edge;
	logic y_edge;
	rgb_t color_next;

	// bit CELL_LOG2 flips once per cell
	assign x_cell = beat_in.x[CELL_LOG2];
	assign y_cell = beat_in.y[CELL_LOG2];

	// a grid line sits on the first column and first row of every cell
	assign x_edge = (beat_in.x[CELL_LOG2-1:0] == '0);
	assign y_edge = (beat_in.y[CELL_LOG2-1:0] == '0);

	// colour choice for the beat that is about to be registered
	// blanking is left to the output stage, so the pattern also runs
	// through the porches and sync area
	always_comb begin
		case (ctrl.mode)
			mode_solid: begin
				color_next = fg;
			end
			mode_bars: begin
				// vertical bars alternate every cell along x
				color_next = x_cell ? bg : fg;
			end
			mode_checker: begin
				// equal cell parity on both axes gives the foreground square
				color_next = (x_cell == y_cell) ? fg : bg;
			end
			mode_grid: begin
				color_next = (x_edge || y_edge) ? fg : bg;
			end
			default: begin
				color_next = fg;
			end
		endcase
	end

	// beat and colour move together on the strobe and hold otherwise
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			beat_out <= beat_idle;
			color <= '0;
		end else if (pix_en) begin
			beat_out <= beat_in;
			color <= color_next;
		end
	end

endmodule

/* vga_regs.sv */
`timescale 1ns/1ps

// configuration registers for control word, foreground and background
// writes land in pending copies and the live copies only move at frame start,
// so one frame is always drawn with a single consistent set of values
module vga_regs import vga_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          wr,
	input  logic [1:0]    addr,
	input  vga_reg_word_u wdata,
	input  logic          frame_start,
	output vga_ctrl_t     ctrl,
	output rgb_t          fg,
	output rgb_t          bg
);

	// power-up picture is black because video_on is off
	// white on black is ready once software turns the output on
	localparam vga_ctrl_t CTRL_RESET = '{
		reserved: 9'd0,
		video_on: 1'b0,
		mode:     mode_solid
	};
	localparam rgb_t FG_RESET = '{red: 4'hf, green: 4'hf, blue: 4'hf};
	localparam rgb_t BG_RESET = '{red: 4'h0, green: 4'h0, blue: 4'h0};

	vga_ctrl_t ctrl_pend;
	rgb_t      fg_pend;
	rgb_t      bg_pend;

	// pending copies
	// the address picks both the register and the view of the data word
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl_pend <= CTRL_RESET;
			fg_pend <= FG_RESET;
			bg_pend <= BG_RESET;
		end else if (wr) begin
			case (addr)
				reg_ctrl: ctrl_pend <= wdata.ctrl;
				reg_fg:   fg_pend <= wdata.color;
				reg_bg:   bg_pend <= wdata.color;
				default:  ;
			endcase
		end
	end

	// live copies
	// a write on the same edge as frame_start waits for the next frame
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl <= CTRL_RESET;
			fg <= FG_RESET;
			bg <= BG_RESET;
		end else if (frame_start) begin
			ctrl <= ctrl_pend;
			fg <= fg_pend;
			bg <= bg_pend;
		end
	end

	// only three registers exist and there is no error response
	assert property (@(posedge clk) disable iff (rst)
		wr |-> (addr < 2'd3));

endmodule

/* vga_timing.sv */
`timescale 1ns/1ps

// raster timing generator
// divides the system clock into a pixel strobe and walks a column and a row
// counter through active area, front porch, sync pulse and back porch
module vga_timing import vga_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33,
	parameter int CLK_DIV  = 4
) (
	input  logic      clk,
	input  logic      rst,
	output logic      pix_en,
	output vga_beat_t beat,
	output logic      frame_start
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	// a divide by one still needs a one bit counter to keep the code legal
	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic [9:0]       h_cnt;
	logic [9:0]       v_cnt;
	logic             h_last;
	logic             v_last;
	logic             h_active;
	logic             v_active;
	logic             h_sync_win;
	logic             v_sync_win;

	// prescaler
	// pix_en is registered, so it rises one clock after the counter
	// reaches its top value and stays low all through reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
			pix_en <= 1'b0;
		end else begin
			if (div_cnt == DIV_W'(CLK_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			pix_en <= (div_cnt == DIV_W'(CLK_DIV - 1));
		end
	end

	assign h_last = (h_cnt == 10'(H_TOTAL - 1));
	assign v_last = (v_cnt == 10'(V_TOTAL - 1));

	// the counters hold the position of the beat that is loaded next
	// the row only moves when the column wraps
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en) begin
			h_cnt <= h_last ? 10'd0 : h_cnt + 10'd1;
			if (h_last)
				v_cnt <= v_last ? 10'd0 : v_cnt + 10'd1;
		end
	end

	// sync windows start right after the front porch
	assign h_active = (h_cnt < 10'(H_ACTIVE));
	assign v_active = (v_cnt < 10'(V_ACTIVE));
	assign h_sync_win = (h_cnt >= 10'(H_ACTIVE + H_FRONT)) &&
		(h_cnt < 10'(H_ACTIVE + H_FRONT + H_SYNC));
	assign v_sync_win = (v_cnt >= 10'(V_ACTIVE + V_FRONT)) &&
		(v_cnt < 10'(V_ACTIVE + V_FRONT + V_SYNC));

	// one beat per strobe, with the flags decoded from the same counter
	// values as the position so they can never drift apart
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			beat <= beat_idle;
		end else if (pix_en) begin
			beat.x <= h_cnt;
			beat.y <= v_cnt;
			beat.active <= h_active && v_active;
			beat.hsync <= !h_sync_win;
			beat.vsync <= !v_sync_win;
		end
	end

	// the configuration block swaps its registers on this pulse
	// it is high exactly on the strobe that loads the top left beat
	assign frame_start = pix_en && (h_cnt == 10'd0) && (v_cnt == 10'd0);

	// a visible pixel inside the horizontal sync pulse means a bad parameter set
	assert property (@(posedge clk) disable iff (rst)
		!(beat.active && !beat.hsync));

	// the strobe has to be a single clock pulse once the clock is divided
	assert property (@(posedge clk) disable iff (rst)
		(CLK_DIV > 1 && pix_en) |=> !pix_en);

endmodule

/* vga_pkg.sv */
// shared types and register addresses for the VGA display controller
// the timing numbers are module parameters, so nothing here depends on the
// screen geometry
package vga_pkg;

	// one 12-bit colour as it goes to the resistor DAC on the board
	// red sits in the top nibble so the word reads as 12'hrgb
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	// everything the later stages need to know about one pixel period
	// x and y count from the top left corner of the whole raster,
	// including the blanking area
	// hsync and vsync are already at pin polarity, so low means sync
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;
		logic       hsync;
		logic       vsync;
	} vga_beat_t;

	// the four picture modes of the pattern generator
	typedef enum logic [1:0] {
		mode_solid   = 2'd0,
		mode_bars    = 2'd1,
		mode_checker = 2'd2,
		mode_grid    = 2'd3
	} vga_mode_e;

	// layout of the control register
	// the reserved bits are kept so the word is as wide as a colour
	typedef struct packed {
		logic [8:0] reserved;
		logic       video_on;
		vga_mode_e  mode;
	} vga_ctrl_t;

	// the host always writes a 12-bit word
	// the address tells whether that word is a control word or a colour,
	// so the same bits are read through one of these two views
	typedef union packed {
		vga_ctrl_t ctrl;
		rgb_t      color;
	} vga_reg_word_u;

	// register map of the configuration block
	localparam logic [1:0] reg_ctrl = 2'd0;
	localparam logic [1:0] reg_fg   = 2'd1;
	localparam logic [1:0] reg_bg   = 2'd2;

	// an idle beat is what the pins should show out of reset
	// both syncs high and nothing visible
	localparam vga_beat_t beat_idle = '{
		x:      10'd0,
		y:      10'd0,
		active: 1'b0,
		hsync:  1'b1,
		vsync:  1'b1
	};

endpackage
